/* flist.f */
logic/pp_pkg.sv
logic/pp_sync_fifo.sv
logic/pp_hop_input.sv
logic/pp_path_fsm.sv
logic/pp_hop_output.sv
logic/path_parser.sv
tests/tb_path_parser.sv

/* tests/tb_path_parser.sv */
// Random paths come from a fixed seed, at most four paths are in flight and hop_reset is never used
`timescale 1ns/1ps

module tb_path_parser import pp_pkg::*; ();

   localparam logic [31:0] SEED = 32'h99707dca;
   localparam int N_PATHS         = 32;
   localparam int MAX_FLIGHT      = 4;
   localparam int WATCHDOG_CYCLES = N_PATHS * 400 + 32;

   logic clk, rst_n;
   logic hop_reset0, hop_wr0, hop_eop0, hop_reset1, hop_wr1, hop_eop1;
   hop_t hop_wdata0, hop_wdata1;
   logic meta_valid;
   rci_t meta_rci;
   logic hop_ready;
   logic hop_full0, hop_fullm1_0, hop_full1, hop_fullm1_1, parse_done0, parse_done1;
   logic hop_valid, hop_sop, hop_eop, hop_error;
   hop_t hop_data;

   logic [31:0] gen_state;
   logic [31:0] rdy_state;
   hop_t        path_hops[$];
   rci_t        path_meta;
   logic [37:0] exp_q[$];   // Expected beats as sop, eop, error, hop
   int          paths_started, pkts_rcvd, done_total, errors, checks, err_mark;
   int          done_cnt[2];
   logic        bp_on, full_check;

   path_parser u_path_parser (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] lcg(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic int unsigned rand_range(input int unsigned n);
      gen_state = lcg(gen_state);
      return gen_state[31:8] % n;
   endfunction

   function automatic byte_ptr_t rand_ptr();
      return byte_ptr_t'(1 + rand_range(65000));   // Never the initial pointer
   endfunction

   function automatic rci_t rand_rci();
      return rci_t'(rand_range(65536));
   endfunction

   function automatic hop_kind_t rand_kind();
      return hop_kind_t'(rand_range(8));
   endfunction

   task automatic add_hop(input hop_kind_t kind, input rci_t rci, input byte_ptr_t ptr);
      path_hops.push_back({kind, rci, ptr});
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Path generator
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic build_path(input int ptype);
      int   nfill;
      int   k;
      int   lead;
      rci_t cur_rci;
      path_hops.delete();
      path_meta = rci_t'(256 + rand_range(60000));   // Static, above the dynamic range
      cur_rci   = rand_range(2) ? path_meta : rci_t'(1 + rand_range(255));
      nfill     = rand_range(4);
      case (ptype)
         1: begin
            cur_rci = rci_t'(1 + rand_range(255));
            add_hop(KIND_START_PROCESS, rand_rci(), rand_ptr());
            add_hop(KIND_START_PROCESS, rand_rci(), rand_ptr());
            add_hop(KIND_START_THREAD, rand_rci(), rand_ptr());
            add_hop(KIND_START_PROCESS_THREAD, rand_rci(), rand_ptr());
            add_hop(KIND_END_PROCESS, rand_rci(), rand_ptr());
            add_hop(KIND_END_THREAD_PROCESS, rand_rci(), rand_ptr());
            add_hop(KIND_END_PROCESS, rand_rci(), rand_ptr());   // Closes the previous process
            add_hop(rand_kind(), '0, rand_ptr());
            add_hop(rand_kind(), cur_rci, rand_ptr());
            add_hop(rand_kind(), '0, rand_ptr());
            add_hop(rand_kind(), rci_t'(1 + rand_range(65535)), rand_ptr());
         end
         2: begin
            lead = rand_range(2);
            if (lead != 0) add_hop(KIND_START_THREAD, rand_rci(), rand_ptr());
            add_hop(rand_kind(), rci_t'(path_meta + 1), lead ? rand_ptr() : INITIAL_HOP_PTR);
            nfill = 2 + rand_range(4);
         end
         3: begin
            add_hop(rand_range(2) ? KIND_START_END_THREAD : KIND_END_THREAD,
                    rand_rci(), rand_ptr());
            add_hop(KIND_START_PROCESS, rand_rci(), rand_ptr());
            add_hop(KIND_END_PROCESS, rand_rci(), rand_ptr());
            add_hop(KIND_START_THREAD, rci_t'(1 + rand_range(255)), rand_ptr());
            nfill = 0;   // Path ends while still skipping
         end
         5: begin
            add_hop(KIND_START_THREAD, rand_rci(), rand_ptr());
            add_hop(rand_kind(), cur_rci, rand_ptr());
            add_hop(rand_kind(), rci_t'(1 + rand_range(65535)), rand_ptr());
         end
         default: begin
            add_hop(rand_kind(), cur_rci, INITIAL_HOP_PTR);
            add_hop(rand_kind(), rci_t'(1 + rand_range(65535)), rand_ptr());
            if (ptype == 4) nfill = rand_range(2);
         end
      endcase
      for (k = 0; k < nfill; k++) add_hop(rand_kind(), rand_rci(), rand_ptr());
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Reference model
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic model_path();
      parse_state_e st;
      int           i;
      int           lev;
      logic         done;
      logic         last;
      logic         dummy;
      logic         dyn;
      hop_kind_t    kind;
      rci_t         rci;
      byte_ptr_t    ptr;
      byte_ptr_t    prev_ptr;
      hop_t         fwd;
      hop_t         first;
      st       = PREV_START;
      i        = 0;
      lev      = 0;
      done     = 1'b0;
      prev_ptr = '0;
      first    = '0;
      while (!done) begin
         {kind, rci, ptr} = path_hops[i];
         last  = (i == path_hops.size() - 1);
         dummy = (rci == '0);
         dyn   = !dummy && (rci <= DYN_RCI_MAX);
         if (st == PREV_START) prev_ptr = ptr;
         fwd = dyn ? {kind, rci, prev_ptr} : path_hops[i];
         i++;
         case (st)
            PREV_START: begin
               if (ptr == INITIAL_HOP_PTR) begin
                  st = CUR_START;
                  i--;   // Looked at, not consumed
               end else if (last) begin
                  exp_q.push_back({3'b111, fwd});
                  done = 1'b1;
               end else if (kind == KIND_START_PROCESS || kind == KIND_END_THREAD ||
                            kind == KIND_START_END_THREAD) begin
                  st = SKIP_PREV;
               end else begin
                  st = CUR_START;
               end
            end
            SKIP_PREV: begin
               if (last) begin
                  exp_q.push_back({3'b111, fwd});
                  done = 1'b1;
               end else if (kind == KIND_START_PROCESS || kind == KIND_START_PROCESS_THREAD) begin
                  lev++;
               end else if (kind == KIND_END_PROCESS || kind == KIND_END_THREAD_PROCESS) begin
                  if (lev == 0) st = CUR_START;
                  else lev--;
               end
            end
            CUR_START: begin
               if (last || (!dummy && !dyn && rci != path_meta)) begin
                  exp_q.push_back({3'b111, fwd});
                  done = 1'b1;
               end else if (!dummy) begin
                  first = fwd;
                  st    = NXT_START;
               end
            end
            NXT_START: begin
               if (!dummy) begin
                  exp_q.push_back({3'b100, first});
                  exp_q.push_back({3'b010, fwd});
                  if (last) done = 1'b1;
                  else st = DRAIN;
               end else if (last) begin
                  exp_q.push_back({3'b111, fwd});   // Collapsed to its eop beat
                  done = 1'b1;
               end
            end
            default: done = last;
         endcase
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Writer
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic drive_hop(input int b, input logic wr, input hop_t data, input logic eop);
      if (b == 0) begin
         hop_wr0    = wr;
         hop_wdata0 = data;
         hop_eop0   = eop;
      end else begin
         hop_wr1    = wr;
         hop_wdata1 = data;
         hop_eop1   = eop;
      end
   endtask

   task automatic write_path(input int k);
      int b;
      int i;
      b = k % 2;
      // Buffer b is free once its previous path is done
      while (paths_started - pkts_rcvd >= MAX_FLIGHT || paths_started - done_total >= MAX_FLIGHT
             || done_cnt[b] < k / 2) @(posedge clk);
      @(negedge clk);
      meta_valid = 1'b1;
      meta_rci   = path_meta;
      paths_started++;
      @(negedge clk);
      meta_valid = 1'b0;
      for (i = 0; i < path_hops.size(); i++) begin
         drive_hop(b, 1'b0, '0, 1'b0);
         while (b == 0 ? hop_full0 : hop_full1) @(negedge clk);
         drive_hop(b, 1'b1, path_hops[i], i == path_hops.size() - 1);
         @(negedge clk);
      end
      drive_hop(b, 1'b0, '0, 1'b0);
   endtask

   task automatic run_path(input int ptype);
      build_path(ptype);
      model_path();
      write_path(paths_started);
   endtask

   task automatic begin_test(input logic bp, input logic fc);
      @(posedge clk);
      bp_on      = bp;
      full_check = fc;
      err_mark   = errors;
   endtask

   task automatic finish_test(input int num, input string name);
      while (pkts_rcvd < paths_started || done_total < paths_started) @(posedge clk);
      assert (done_cnt[0] == (paths_started + 1) / 2 && done_cnt[1] == paths_started / 2)
      else begin
         $display("parse_done counts %0d and %0d do not fit %0d paths",
                  done_cnt[0], done_cnt[1], paths_started);
         errors++;
      end
      $display("test %0d %s: %s with %0d errors", num, name,
               (errors == err_mark) ? "passed" : "failed", errors - err_mark);
   endtask

   task automatic check_field(input string name, input hop_t exp, input hop_t got);
      checks++;
      assert (exp === got)
      else begin
         $display("error at %0t ns: %s expected %h got %h", $time, name, exp, got);
         errors++;
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Output monitor and ready driver
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   initial begin
      logic [37:0] beat;
      logic [37:0] held_beat;
      logic [37:0] exp;
      logic        held;
      held      = 1'b0;
      held_beat = '0;
      hop_ready = 1'b0;
      rdy_state = lcg(SEED ^ 32'h5a5a5a5a);
      forever begin
         @(negedge clk);
         beat = {hop_sop, hop_eop, hop_error, hop_data};
         if (held) begin
            assert (hop_valid && beat === held_beat)
            else begin
               $display("error at %0t ns: output beat changed while hop_ready was low", $time);
               errors++;
            end
         end
         rdy_state = lcg(rdy_state);
         hop_ready = bp_on ? rdy_state[20] : 1'b1;
         if (hop_valid && hop_ready) begin
            if (exp_q.size() == 0) begin
               $display("error at %0t ns: output beat arrived with none expected", $time);
               errors++;
            end else begin
               exp = exp_q.pop_front();
               check_field("hop_data", exp[34:0], hop_data);
               check_field("hop_sop", exp[37], hop_sop);
               check_field("hop_eop", exp[36], hop_eop);
               check_field("hop_error", exp[35], hop_error);
               if (exp[36]) pkts_rcvd++;
            end
         end
         held      = hop_valid && !hop_ready;
         held_beat = beat;
         if (parse_done0 || parse_done1) begin
            assert (!(parse_done0 && parse_done1) && parse_done0 == (done_total % 2 == 0))
            else begin
               $display("error at %0t ns: parse_done pulse out of path order", $time);
               errors++;
            end
            done_cnt[0] += parse_done0;
            done_cnt[1] += parse_done1;
            done_total  += parse_done0 + parse_done1;
         end
         if (full_check) begin
            // Paths of three hops or less never fill a buffer beyond two entries
            assert (!hop_full0 && !hop_full1 && !hop_fullm1_0 && !hop_fullm1_1)
            else begin
               $display("error at %0t ns: %s expected 0000 got %b%b%b%b", $time,
                        "hop_full0, hop_full1, hop_fullm1_0, hop_fullm1_1",
                        hop_full0, hop_full1, hop_fullm1_0, hop_fullm1_1);
               errors++;
            end
         end
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: run did not end within %0d cycles", WATCHDOG_CYCLES);
      $display("FAIL: see errors above");
      $finish;
   end

   initial begin
      int mix[5];
      mix           = '{0, 1, 2, 3, 5};
      rst_n         = 1'b0;
      hop_reset0    = 1'b0;
      hop_reset1    = 1'b0;
      meta_valid    = 1'b0;
      meta_rci      = '0;
      drive_hop(0, 1'b0, '0, 1'b0);
      drive_hop(1, 1'b0, '0, 1'b0);
      gen_state     = SEED;
      paths_started = 0;
      pkts_rcvd     = 0;
      done_total    = 0;
      done_cnt      = '{0, 0};
      errors        = 0;
      checks        = 0;
      err_mark      = 0;
      bp_on         = 1'b0;
      full_check    = 1'b0;
      repeat (16) @(negedge clk);
      rst_n = 1'b1;

      begin_test(1'b0, 1'b0);
      repeat (4) run_path(0);
      finish_test(1, "matched path");

      begin_test(1'b0, 1'b0);
      run_path(1);
      run_path(5);
      run_path(1);
      run_path(1);
      finish_test(2, "previous process skip");

      begin_test(1'b0, 1'b0);
      run_path(2);
      run_path(3);
      run_path(2);
      run_path(3);
      finish_test(3, "mismatch and early end");

      begin_test(1'b0, 1'b1);
      repeat (8) run_path(4);
      finish_test(4, "ping-pong and parse done");

      begin_test(1'b1, 1'b0);
      repeat (12) run_path(mix[rand_range(5)]);
      finish_test(5, "back-pressure");

      assert (exp_q.size() == 0)
      else begin
         $display("%0d expected beats never arrived", exp_q.size());
         errors++;
      end
      $display("tests 5, paths %0d, checks %0d, errors %0d", paths_started, checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

/* logic/path_parser.sv */
// Writer keeps paths alternating from buffer 0, pushes one meta rci per path first, stays four ahead
`timescale 1ns/1ps

module path_parser import pp_pkg::*; (
   input  logic clk,
   input  logic rst_n,
   input  logic hop_reset0,
   input  logic hop_wr0,
   input  hop_t hop_wdata0,
   input  logic hop_eop0,
   input  logic hop_reset1,
   input  logic hop_wr1,
   input  hop_t hop_wdata1,
   input  logic hop_eop1,
   input  logic meta_valid,
   input  rci_t meta_rci,
   input  logic hop_ready,
   output logic hop_full0,
   output logic hop_fullm1_0,
   output logic hop_full1,
   output logic hop_fullm1_1,
   output logic parse_done0,
   output logic parse_done1,
   output logic hop_valid,
   output hop_t hop_data,
   output logic hop_sop,
   output logic hop_eop,
   output logic hop_error
);

   logic hop_avail, cur_eop, cur_dummy, cur_initial, cur_dynamic, cur_match;
   logic hop_take, path_end;
   logic beat_wr, beat_sop, beat_eop, beat_error;
   hop_t cur_hop;
   hop_t beat_hop;

   pp_hop_input u_input (
      .clk, .rst_n,
      .hop_reset0, .hop_wr0, .hop_wdata0, .hop_eop0,
      .hop_reset1, .hop_wr1, .hop_wdata1, .hop_eop1,
      .meta_valid, .meta_rci, .hop_take, .path_end,
      .hop_full0, .hop_fullm1_0, .hop_full1, .hop_fullm1_1,
      .parse_done0, .parse_done1,
      .hop_avail, .cur_hop, .cur_eop, .cur_dummy, .cur_initial, .cur_dynamic, .cur_match
   );

   pp_path_fsm u_fsm (
      .clk, .rst_n,
      .hop_avail, .cur_hop, .cur_eop, .cur_dummy, .cur_initial, .cur_dynamic, .cur_match,
      .hop_take, .path_end,
      .beat_wr, .beat_hop, .beat_sop, .beat_eop, .beat_error
   );

   pp_hop_output u_output (
      .clk, .rst_n,
      .beat_wr, .beat_hop, .beat_sop, .beat_eop, .beat_error,
      .hop_ready,
      .hop_valid, .hop_data, .hop_sop, .hop_eop, .hop_error
   );

endmodule

/* logic/pp_hop_output.sv */
// Beat and packet FIFOs accept writes with no back-pressure, so at most four packets may wait here
`timescale 1ns/1ps

module pp_hop_output import pp_pkg::*; (
   input  logic clk,
   input  logic rst_n,
   input  logic beat_wr,
   input  hop_t beat_hop,
   input  logic beat_sop,
   input  logic beat_eop,
   input  logic beat_error,
   input  logic hop_ready,
   output logic hop_valid,
   output hop_t hop_data,
   output logic hop_sop,
   output logic hop_eop,
   output logic hop_error
);

   hop_t q_hop;
   logic q_sop;
   logic q_eop;
   logic q_empty;
   logic pkt_error;
   logic pkt_empty;
   logic out_full;
   logic out_empty;
   logic move;
   logic out_wr;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Beats wait for their packet's verdict
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   pp_sync_fifo #(.WIDTH(2 + $bits(hop_t)), .DEPTH(OUT_FIFO_DEPTH)) u_beat_fifo (
      .clk         (clk),
      .rst_n       (rst_n),
      .clear       (1'b0),
      .wr          (beat_wr),
      .din         ({beat_sop, beat_eop, beat_hop}),
      .rd          (move),
      .dout        ({q_sop, q_eop, q_hop}),
      .full        (),
      .almost_full (),
      .empty       (q_empty)
   );

   // One flag per packet, written with the eop beat
   pp_sync_fifo #(.WIDTH(1), .DEPTH(PKT_FIFO_DEPTH)) u_pkt_fifo (
      .clk         (clk),
      .rst_n       (rst_n),
      .clear       (1'b0),
      .wr          (beat_wr & beat_eop),
      .din         (beat_error),
      .rd          (move & q_eop),
      .dout        (pkt_error),
      .full        (),
      .almost_full (),
      .empty       (pkt_empty)
   );

   assign move   = ~q_empty & ~pkt_empty & ~out_full;
   assign out_wr = move & (q_eop | ~pkt_error);   // Error packets keep only the eop beat

   pp_sync_fifo #(.WIDTH(3 + $bits(hop_t)), .DEPTH(OUT_FIFO_DEPTH)) u_out_fifo (
      .clk         (clk),
      .rst_n       (rst_n),
      .clear       (1'b0),
      .wr          (out_wr),
      .din         ({q_sop | pkt_error, q_eop, pkt_error, q_hop}),
      .rd          (hop_valid & hop_ready),
      .dout        ({hop_sop, hop_eop, hop_error, hop_data}),
      .full        (out_full),
      .almost_full (),
      .empty       (out_empty)
   );

   assign hop_valid = ~out_empty;

endmodule

/* logic/pp_path_fsm.sv */
// Process nesting beyond 15 levels wraps, and hops after the forwarded next hop are discarded
`timescale 1ns/1ps

module pp_path_fsm import pp_pkg::*; (
   input  logic clk,
   input  logic rst_n,
   input  logic hop_avail,
   input  hop_t cur_hop,
   input  logic cur_eop,
   input  logic cur_dummy,
   input  logic cur_initial,
   input  logic cur_dynamic,
   input  logic cur_match,
   output logic hop_take,
   output logic path_end,
   output logic beat_wr,
   output hop_t beat_hop,
   output logic beat_sop,
   output logic beat_eop,
   output logic beat_error
);

   parse_state_e state, state_nxt;
   proc_lev_t    proc_lev;
   byte_ptr_t    prev_ptr;
   byte_ptr_t    cur_ptr;
   byte_ptr_t    fwd_ptr;
   hop_kind_t    kind;
   logic         ptr_load;
   logic         lev_inc;
   logic         lev_dec;
   logic         lev_clr;
   logic         fail;   // Path ends with a single error beat
   logic         fin;

   assign kind    = cur_hop[HOP_KIND_LSB +: $bits(hop_kind_t)];
   assign cur_ptr = cur_hop[HOP_PTR_LSB +: $bits(byte_ptr_t)];

   // The previous hop keeps its own pointer, later hops use the recorded one
   assign fwd_ptr = (state == PREV_START) ? cur_ptr : prev_ptr;

   always_comb begin
      beat_hop = cur_hop;
      if (cur_dynamic) beat_hop[HOP_PTR_LSB +: $bits(byte_ptr_t)] = fwd_ptr;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Path walk
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      state_nxt  = state;
      hop_take   = 1'b0;
      path_end   = 1'b0;
      ptr_load   = 1'b0;
      lev_inc    = 1'b0;
      lev_dec    = 1'b0;
      lev_clr    = 1'b0;
      beat_wr    = 1'b0;
      beat_sop   = 1'b0;
      beat_eop   = 1'b0;
      beat_error = 1'b0;
      fail       = 1'b0;
      fin        = 1'b0;

      if (hop_avail) begin
         case (state)
            PREV_START: begin
               ptr_load = 1'b1;
               if (cur_initial) begin
                  state_nxt = CUR_START;   // Examined, left for CUR_START
               end else begin
                  hop_take = 1'b1;
                  if (cur_eop) begin
                     fail = 1'b1;
                  end else begin
                     case (kind)
                        KIND_START_PROCESS, KIND_END_THREAD, KIND_START_END_THREAD:
                           state_nxt = SKIP_PREV;
                        default:
                           state_nxt = CUR_START;
                     endcase
                  end
               end
            end

            SKIP_PREV: begin
               hop_take = 1'b1;
               if (cur_eop) begin
                  fail = 1'b1;
               end else begin
                  case (kind)
                     KIND_START_PROCESS, KIND_START_PROCESS_THREAD:
                        lev_inc = 1'b1;
                     KIND_END_PROCESS, KIND_END_THREAD_PROCESS:
                        if (proc_lev == '0) state_nxt = CUR_START;
                        else lev_dec = 1'b1;
                     default: ;
                  endcase
               end
            end

            CUR_START: begin
               hop_take = 1'b1;
               if (cur_eop || (!cur_dummy && !cur_match)) begin
                  fail = 1'b1;
               end else if (!cur_dummy) begin
                  beat_wr   = 1'b1;
                  beat_sop  = 1'b1;
                  state_nxt = NXT_START;
               end
            end

            NXT_START: begin
               hop_take = 1'b1;
               if (!cur_dummy) begin
                  beat_wr  = 1'b1;
                  beat_eop = 1'b1;
                  if (cur_eop) fin = 1'b1;
                  else state_nxt = DRAIN;
               end else if (cur_eop) begin
                  // Path ran out before a next hop, so the packet closes as an error
                  beat_wr    = 1'b1;
                  beat_eop   = 1'b1;
                  beat_error = 1'b1;
                  fin        = 1'b1;
               end
            end

            DRAIN: begin
               hop_take = 1'b1;
               fin      = cur_eop;
            end

            default: state_nxt = PREV_START;
         endcase
      end

      if (fail) begin
         beat_wr    = 1'b1;
         beat_sop   = 1'b1;
         beat_eop   = 1'b1;
         beat_error = 1'b1;
         fin        = 1'b1;
      end
      if (fin) begin
         path_end  = 1'b1;
         lev_clr   = 1'b1;
         state_nxt = PREV_START;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= PREV_START;
         proc_lev <= '0;
      end else begin
         state <= state_nxt;
         if (lev_clr) proc_lev <= '0;
         else if (lev_inc) proc_lev <= proc_lev + 1'b1;
         else if (lev_dec) proc_lev <= proc_lev - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (ptr_load) prev_ptr <= cur_ptr;
   end

endmodule

/* logic/pp_hop_input.sv */
// Paths alternate between buffers from buffer 0, and a path's meta rci must be pushed before its hops
`timescale 1ns/1ps

module pp_hop_input import pp_pkg::*; (
   input  logic clk,
   input  logic rst_n,
   input  logic hop_reset0,
   input  logic hop_wr0,
   input  hop_t hop_wdata0,
   input  logic hop_eop0,
   input  logic hop_reset1,
   input  logic hop_wr1,
   input  hop_t hop_wdata1,
   input  logic hop_eop1,
   input  logic meta_valid,
   input  rci_t meta_rci,
   input  logic hop_take,
   input  logic path_end,
   output logic hop_full0,
   output logic hop_fullm1_0,
   output logic hop_full1,
   output logic hop_fullm1_1,
   output logic parse_done0,
   output logic parse_done1,
   output logic hop_avail,
   output hop_t cur_hop,
   output logic cur_eop,
   output logic cur_dummy,
   output logic cur_initial,
   output logic cur_dynamic,
   output logic cur_match
);

   logic       sel;   // Buffer of the path being parsed
   logic [1:0] wr_v, eop_v, reset_v, end_v;
   logic [1:0] buf_wr, buf_rd, buf_clr, buf_empty, buf_eop, buf_full, buf_fullm1;
   logic [1:0] open, open_nxt, drop;
   hop_t       wdata_v [2];
   hop_t       buf_hop [2];
   hop_t       head_hop;
   rci_t       head_rci, meta_head;
   logic       head_empty, head_eop, load, flush;

   assign wr_v       = {hop_wr1, hop_wr0};
   assign eop_v      = {hop_eop1, hop_eop0};
   assign reset_v    = {hop_reset1, hop_reset0};
   assign wdata_v[0] = hop_wdata0;
   assign wdata_v[1] = hop_wdata1;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Hop buffers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   for (genvar i = 0; i < 2; i++) begin : g_buf
      assign end_v[i]    = path_end & (sel == 1'(i));
      assign buf_wr[i]   = wr_v[i] & ~drop[i];
      assign buf_rd[i]   = load & (sel == 1'(i));
      assign buf_clr[i]  = reset_v[i] | end_v[i];   // Leftover hops of a finished path go
      assign open_nxt[i] = buf_wr[i] ? ~eop_v[i] : open[i];

      // A path that ended before its eop was written drops the late writes up to that eop
      always_ff @(posedge clk or negedge rst_n) begin
         if (!rst_n) begin
            open[i] <= 1'b0;
            drop[i] <= 1'b0;
         end else if (reset_v[i]) begin
            open[i] <= 1'b0;
            drop[i] <= 1'b0;
         end else begin
            open[i] <= open_nxt[i] & ~end_v[i];
            if (end_v[i]) drop[i] <= open_nxt[i];
            else if (wr_v[i] & eop_v[i]) drop[i] <= 1'b0;
         end
      end

      pp_sync_fifo #(.WIDTH(1 + $bits(hop_t)), .DEPTH(HOP_FIFO_DEPTH)) u_hop_fifo (
         .clk         (clk),
         .rst_n       (rst_n),
         .clear       (buf_clr[i]),
         .wr          (buf_wr[i]),
         .din         ({eop_v[i], wdata_v[i]}),
         .rd          (buf_rd[i]),
         .dout        ({buf_eop[i], buf_hop[i]}),
         .full        (buf_full[i]),
         .almost_full (buf_fullm1[i]),
         .empty       (buf_empty[i])
      );
   end

   assign hop_full0    = buf_full[0];
   assign hop_full1    = buf_full[1];
   assign hop_fullm1_0 = buf_fullm1[0];
   assign hop_fullm1_1 = buf_fullm1[1];

   pp_sync_fifo #(.WIDTH($bits(rci_t)), .DEPTH(META_FIFO_DEPTH)) u_meta_fifo (
      .clk         (clk),
      .rst_n       (rst_n),
      .clear       (1'b0),
      .wr          (meta_valid),
      .din         (meta_rci),
      .rd          (path_end),
      .dout        (meta_head),
      .full        (),
      .almost_full (),
      .empty       ()
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Prefetch and classification
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign head_empty = buf_empty[sel];
   assign head_hop   = buf_hop[sel];
   assign head_eop   = buf_eop[sel];
   assign head_rci   = head_hop[HOP_RCI_LSB +: $bits(rci_t)];
   assign flush      = path_end | reset_v[sel];
   assign load       = ~head_empty & ~flush & (~hop_avail | hop_take);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) hop_avail <= 1'b0;
      else if (flush) hop_avail <= 1'b0;
      else if (load) hop_avail <= 1'b1;
      else if (hop_take) hop_avail <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (load) begin
         cur_hop     <= head_hop;
         cur_eop     <= head_eop;
         cur_dummy   <= (head_rci == '0);
         cur_initial <= (head_hop[HOP_PTR_LSB +: $bits(byte_ptr_t)] == INITIAL_HOP_PTR);
         cur_dynamic <= (head_rci != '0) && (head_rci <= DYN_RCI_MAX);
         cur_match   <= ((head_rci != '0) && (head_rci <= DYN_RCI_MAX)) || (head_rci == meta_head);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sel         <= 1'b0;
         parse_done0 <= 1'b0;
         parse_done1 <= 1'b0;
      end else begin
         sel         <= sel ^ path_end;
         parse_done0 <= end_v[0];
         parse_done1 <= end_v[1];
      end
   end

endmodule

/* logic/pp_sync_fifo.sv */
// Head entry shows on dout without a read, writes into a full FIFO are dropped unless a read pops
`timescale 1ns/1ps

module pp_sync_fifo #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 4
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             clear,
   input  logic             wr,
   input  logic [WIDTH-1:0] din,
   input  logic             rd,
   output logic [WIDTH-1:0] dout,
   output logic             full,
   output logic             almost_full,
   output logic             empty
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_wr;
   logic             do_rd;

   // Pointers wrap at DEPTH so any depth works
   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign do_rd       = rd & ~empty;
   assign do_wr       = wr & (~full | do_rd);
   assign empty       = (count == '0);
   assign full        = (count == CNT_W'(DEPTH));
   assign almost_full = (count >= CNT_W'(DEPTH - 1));   // One entry left
   assign dout        = mem[rd_ptr];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) wr_ptr <= ptr_next(wr_ptr);
         if (do_rd) rd_ptr <= ptr_next(rd_ptr);
         count <= count + CNT_W'(do_wr) - CNT_W'(do_rd);
      end
   end

   always_ff @(posedge clk) begin
      if (do_wr) mem[wr_ptr] <= din;
   end

endmodule

/* logic/pp_pkg.sv */
// Hop words are packed as kind over rci over byte pointer and all buffer depths are fixed here
package pp_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Hop fields
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef logic [2:0]  hop_kind_t;
   typedef logic [15:0] rci_t;
   typedef logic [15:0] byte_ptr_t;
   typedef logic [34:0] hop_t;
   typedef logic [3:0]  proc_lev_t;

   // Bit positions inside hop_t
   localparam int HOP_PTR_LSB  = 0;
   localparam int HOP_RCI_LSB  = HOP_PTR_LSB + $bits(byte_ptr_t);
   localparam int HOP_KIND_LSB = HOP_RCI_LSB + $bits(rci_t);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Hop kind codes
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam hop_kind_t KIND_NULL                 = 3'd0;
   localparam hop_kind_t KIND_START_PROCESS        = 3'd1;
   localparam hop_kind_t KIND_START_THREAD         = 3'd2;
   localparam hop_kind_t KIND_START_PROCESS_THREAD = 3'd3;
   localparam hop_kind_t KIND_START_END_THREAD     = 3'd4;
   localparam hop_kind_t KIND_END_PROCESS          = 3'd5;
   localparam hop_kind_t KIND_END_THREAD           = 3'd6;
   localparam hop_kind_t KIND_END_THREAD_PROCESS   = 3'd7;

   // A path whose current hop is also its first hop
   localparam byte_ptr_t INITIAL_HOP_PTR = 16'd0;

   localparam rci_t DYN_RCI_MAX = 16'd255;   // Dynamic rci range is 1 to this value

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Buffer depths
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam int HOP_FIFO_DEPTH  = 4;
   localparam int META_FIFO_DEPTH = 4;
   localparam int OUT_FIFO_DEPTH  = 16;
   localparam int PKT_FIFO_DEPTH  = 4;

   // Parser states
   typedef enum logic [2:0] {
      PREV_START,
      SKIP_PREV,
      CUR_START,
      NXT_START,
      DRAIN
   } parse_state_e;

endpackage
